// File: tinker_core.f
+incdir+testbench
common/tinker_isa_pkg.sv
common/tinker_core_pkg.sv
hdl/tinker_regfile.sv
hdl/tinker_memory.sv
execute/tinker_alu.sv
execute/tinker_branch_unit.sv
control/tinker_sequencer.sv
hdl/tinker_core.sv
testbench/tinker_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tinker_core.f --top-module tinker_core_tb \
    --Mdir obj_dir -o tinker_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tinker_core_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
    exit 1
fi
exit 0

// File: testbench/tinker_programs.svh
// Instruction encoders and program loader for the tinker core testbench, included in its top module
`ifndef TINKER_PROGRAMS_SVH
`define TINKER_PROGRAMS_SVH

    function automatic tinker_isa_pkg::instr_t encode_instr(
        input tinker_isa_pkg::opcode_t  op,
        input tinker_isa_pkg::reg_idx_t rd,
        input tinker_isa_pkg::reg_idx_t rs,
        input tinker_isa_pkg::reg_idx_t rt,
        input tinker_isa_pkg::literal_t l
    );
        tinker_isa_pkg::instr_t w;
        w.opcode = op;
        w.rd     = rd;
        w.rs     = rs;
        w.rt     = rt;
        w.l      = l;
        return w;
    endfunction

    // Core sits in reset while the new program goes in at the reset PC
    task automatic begin_program();
        @(posedge clk);
        reset <= 1'b1;
        prog_ptr = PROG_BASE;
    endtask

    task automatic write_word(input tinker_isa_pkg::instr_t w);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= prog_ptr;
        prog_data <= w;
        prog_ptr  = prog_ptr + 32'd4;    // Next instruction slot
    endtask

    task automatic end_program();
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic reg_op(input tinker_isa_pkg::opcode_t op, input tinker_isa_pkg::reg_idx_t rd,
                          input tinker_isa_pkg::reg_idx_t rs, input tinker_isa_pkg::reg_idx_t rt);
        write_word(encode_instr(op, rd, rs, rt, 12'h000));
    endtask

    task automatic lit_op(input tinker_isa_pkg::opcode_t op, input tinker_isa_pkg::reg_idx_t rd,
                          input tinker_isa_pkg::reg_idx_t rs, input tinker_isa_pkg::literal_t l);
        write_word(encode_instr(op, rd, rs, 5'd0, l));
    endtask

    // Top 4 bits first, then five 12-bit chunks shifted in from below
    task automatic load_constant(input tinker_isa_pkg::reg_idx_t rd,
                                 input tinker_core_pkg::word_t value);
        lit_op(tinker_isa_pkg::OP_MOV_L, rd, 5'd0, {8'h00, value[63:60]});
        for (int i = 4; i >= 0; i--) begin
            lit_op(tinker_isa_pkg::OP_SHFTLI, rd, 5'd0, 12'd12);
            lit_op(tinker_isa_pkg::OP_MOV_L, rd, 5'd0, value[12*i +: 12]);
        end
    endtask

`endif

// File: testbench/tinker_core_tb.sv
// Directed testbench for the tinker core; loads small programs, runs them to halt, checks registers
`timescale 1ns/1ps

module tinker_core_tb;

    localparam tinker_core_pkg::addr_t PROG_BASE    = 32'h0000_2000;
    localparam int                     HALT_TIMEOUT = 200;

    logic                     clk;
    logic                     reset;
    logic                     prog_we;
    tinker_core_pkg::addr_t   prog_addr;
    tinker_isa_pkg::instr_t   prog_data;
    tinker_isa_pkg::reg_idx_t dbg_addr;
    tinker_core_pkg::word_t   dbg_data;
    logic                     hlt;

    tinker_core_pkg::addr_t   prog_ptr;
    int                       seed   = 32'hb0aa;
    int                       errors = 0;
    int                       checks = 0;

    tinker_core dut0 (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .hlt       (hlt)
    );

    always #50 clk = ~clk;

    `include "tinker_programs.svh"

    task automatic check_word(input string name, input tinker_core_pkg::word_t got,
                              input tinker_core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Address goes out on a rising edge, data is taken at the falling edge
    task automatic read_reg(input tinker_isa_pkg::reg_idx_t idx,
                            output tinker_core_pkg::word_t val);
        @(posedge clk);
        dbg_addr <= idx;
        @(negedge clk);
        val = dbg_data;
    endtask

    task automatic expect_reg(input tinker_isa_pkg::reg_idx_t idx,
                              input tinker_core_pkg::word_t exp);
        tinker_core_pkg::word_t val;
        read_reg(idx, val);
        check_word($sformatf("dbg_data[r%0d]", idx), val, exp);
    endtask

    // Cycles counts rising edges from reset release until hlt is seen
    task automatic run_to_halt(output int cycles);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        cycles = 0;
        while (!hlt && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!hlt) begin
            errors++;
            $display("Timeout: hlt did not rise within %0d cycles of reset release", HALT_TIMEOUT);
        end
    endtask

    task automatic arithmetic_results();
        tinker_core_pkg::word_t   a;
        tinker_core_pkg::word_t   b;
        tinker_isa_pkg::literal_t la;
        tinker_isa_pkg::literal_t ls;
        int                       cycles;
        a  = {$random(seed), $random(seed)};
        b  = {$random(seed), $random(seed)};
        la = tinker_isa_pkg::literal_t'($random(seed)) | 12'h800;  // Top bit set so extension shows
        ls = tinker_isa_pkg::literal_t'($random(seed)) | 12'h800;
        begin_program();
        load_constant(5'd1, a);
        load_constant(5'd2, b);
        reg_op(tinker_isa_pkg::OP_ADD, 5'd3, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_SUB, 5'd4, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_MUL, 5'd5, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd6, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_ADDI, 5'd6, 5'd0, la);  // Immediates work on rd in place
        reg_op(tinker_isa_pkg::OP_MOV, 5'd7, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_SUBI, 5'd7, 5'd0, ls);
        lit_op(tinker_isa_pkg::OP_HALT, 5'd0, 5'd0, 12'h000);
        end_program();
        run_to_halt(cycles);
        expect_reg(5'd1, a);
        expect_reg(5'd2, b);
        expect_reg(5'd3, a + b);
        expect_reg(5'd4, a - b);
        expect_reg(5'd5, a * b);
        expect_reg(5'd6, a + tinker_core_pkg::word_t'(la));
        expect_reg(5'd7, a - tinker_core_pkg::word_t'(ls));
    endtask

    task automatic logic_and_shifts();
        tinker_core_pkg::word_t   a;
        tinker_core_pkg::word_t   b;
        tinker_isa_pkg::literal_t kr;
        tinker_isa_pkg::literal_t kl;
        int                       cycles;
        a  = {$random(seed), $random(seed)};
        b  = {$random(seed), $random(seed)};
        kr = tinker_isa_pkg::literal_t'($random(seed) & 32'h3f);
        kl = tinker_isa_pkg::literal_t'($random(seed) & 32'h3f);
        begin_program();
        load_constant(5'd1, a);
        load_constant(5'd2, b);
        reg_op(tinker_isa_pkg::OP_AND, 5'd3, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_OR, 5'd4, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_XOR, 5'd5, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_NOT, 5'd6, 5'd1, 5'd0);
        reg_op(tinker_isa_pkg::OP_SHFTR, 5'd7, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_SHFTL, 5'd8, 5'd1, 5'd2);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd9, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_SHFTRI, 5'd9, 5'd0, kr);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd10, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_SHFTLI, 5'd10, 5'd0, kl);
        lit_op(tinker_isa_pkg::OP_HALT, 5'd0, 5'd0, 12'h000);
        end_program();
        run_to_halt(cycles);
        expect_reg(5'd3, a & b);
        expect_reg(5'd4, a | b);
        expect_reg(5'd5, a ^ b);
        expect_reg(5'd6, ~a);
        expect_reg(5'd7, a >> b[5:0]);   // Amount from low 6 bits of rt
        expect_reg(5'd8, a << b[5:0]);
        expect_reg(5'd9, a >> kr);
        expect_reg(5'd10, a << kl);
    endtask

    task automatic move_and_memory();
        tinker_core_pkg::word_t   a;
        tinker_isa_pkg::literal_t lit;
        int                       cycles;
        a   = {$random(seed), $random(seed)};
        lit = tinker_isa_pkg::literal_t'($random(seed));
        begin_program();
        load_constant(5'd1, a);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd2, 5'd1, 5'd0);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd3, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd3, 5'd0, lit);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd20, 5'd0, 12'h100);
        lit_op(tinker_isa_pkg::OP_STORE, 5'd20, 5'd1, 12'h700);  // mem[0x800] = r1
        lit_op(tinker_isa_pkg::OP_LOAD, 5'd21, 5'd20, 12'h700);
        lit_op(tinker_isa_pkg::OP_HALT, 5'd0, 5'd0, 12'h000);
        end_program();
        run_to_halt(cycles);
        expect_reg(5'd2, a);
        expect_reg(5'd3, {a[63:12], lit});
        expect_reg(5'd20, 64'h100);
        expect_reg(5'd21, a);
    endtask

    // Markers r2, r4, r6 and r9 sit on skipped paths
    task automatic branch_paths();
        int cycles;
        begin_program();
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd1, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_BRR_L, 5'd0, 5'd0, 12'd8);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd2, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd3, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd10, 5'd0, 12'd2);
        lit_op(tinker_isa_pkg::OP_SHFTLI, 5'd10, 5'd0, 12'd12);
        lit_op(tinker_isa_pkg::OP_ADDI, 5'd10, 5'd0, 12'd36);   // Slot 9
        lit_op(tinker_isa_pkg::OP_BR, 5'd10, 5'd0, 12'h000);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd4, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd5, 5'd0, 12'd1);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd11, 5'd10, 5'd0);
        lit_op(tinker_isa_pkg::OP_ADDI, 5'd11, 5'd0, 12'd20);   // Slot 14
        reg_op(tinker_isa_pkg::OP_BRNZ, 5'd11, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd6, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd7, 5'd0, 12'd1);
        reg_op(tinker_isa_pkg::OP_BRNZ, 5'd11, 5'd31, 5'd0);    // r31 is zero
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd8, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd12, 5'd0, 12'd8);
        lit_op(tinker_isa_pkg::OP_BRR_RD, 5'd12, 5'd0, 12'h000);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd9, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd13, 5'd0, 12'd1);
        lit_op(tinker_isa_pkg::OP_HALT, 5'd0, 5'd0, 12'h000);
        end_program();
        run_to_halt(cycles);
        expect_reg(5'd1, 64'd1);
        expect_reg(5'd2, 64'd0);
        expect_reg(5'd3, 64'd1);
        expect_reg(5'd4, 64'd0);
        expect_reg(5'd5, 64'd1);
        expect_reg(5'd6, 64'd0);
        expect_reg(5'd7, 64'd1);
        expect_reg(5'd8, 64'd1);
        expect_reg(5'd9, 64'd0);
        expect_reg(5'd13, 64'd1);
    endtask

    task automatic reset_and_halt();
        tinker_core_pkg::word_t val;
        int                     cycles;
        begin_program();
        lit_op(tinker_isa_pkg::OP_MOV_L, 5'd1, 5'd0, 12'h5a5);
        lit_op(tinker_isa_pkg::OP_ADDI, 5'd1, 5'd0, 12'h010);
        reg_op(tinker_isa_pkg::OP_MOV, 5'd2, 5'd1, 5'd0);
        lit_op(tinker_isa_pkg::OP_HALT, 5'd0, 5'd0, 12'h000);
        end_program();
        @(negedge clk);
        check_bit("hlt", hlt, 1'b0);
        for (int i = 0; i < tinker_core_pkg::NUM_REGS; i++) begin
            expect_reg(tinker_isa_pkg::reg_idx_t'(i), 64'd0);
        end
        run_to_halt(cycles);
        // Three instructions of five cycles, then FETCH and DECODE of halt
        check_word("hlt latency in cycles", tinker_core_pkg::word_t'(cycles),
                   tinker_core_pkg::word_t'(5 * 3 + 2));
        expect_reg(5'd2, 64'h5b5);
        for (int i = 0; i < 20; i++) begin
            read_reg(5'd1, val);
            check_word("dbg_data[r1]", val, 64'h5b5);
        end
        expect_reg(5'd2, 64'h5b5);
        check_bit("hlt", hlt, 1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        prog_ptr  = PROG_BASE;
        arithmetic_results();
        logic_and_shifts();
        move_and_memory();
        branch_paths();
        reset_and_halt();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/tinker_core.sv
// Tinker core top level; connects sequencer, ALU, branch unit, register file and memory
`timescale 1ns/1ps

module tinker_core #(
    parameter int                     MEM_BYTES = 16384,
    parameter tinker_core_pkg::addr_t RESET_PC  = 32'h0000_2000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      prog_we,
    input  tinker_core_pkg::addr_t    prog_addr,
    input  tinker_isa_pkg::instr_t    prog_data,
    input  tinker_isa_pkg::reg_idx_t  dbg_addr,
    output tinker_core_pkg::word_t    dbg_data,
    output logic                      hlt
);

    tinker_isa_pkg::instr_t   fetch_word;
    tinker_isa_pkg::instr_t   instr;
    tinker_core_pkg::addr_t   pc;
    tinker_core_pkg::addr_t   branch_pc;
    tinker_core_pkg::addr_t   mem_addr;
    tinker_core_pkg::word_t   op_a;
    tinker_core_pkg::word_t   op_b;
    tinker_core_pkg::word_t   alu_result;
    tinker_core_pkg::word_t   load_data;
    tinker_core_pkg::word_t   rf_wdata;
    tinker_isa_pkg::reg_idx_t rf_addr_a;
    tinker_isa_pkg::reg_idx_t rf_addr_b;
    tinker_isa_pkg::reg_idx_t rf_waddr;
    logic                     alu_writes;
    logic                     rf_we;
    logic                     store_en;

    tinker_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .fetch_word (fetch_word),
        .op_a       (op_a),
        .alu_result (alu_result),
        .alu_writes (alu_writes),
        .branch_pc  (branch_pc),
        .load_data  (load_data),
        .instr      (instr),
        .pc         (pc),
        .rf_addr_a  (rf_addr_a),
        .rf_addr_b  (rf_addr_b),
        .rf_waddr   (rf_waddr),
        .rf_we      (rf_we),
        .rf_wdata   (rf_wdata),
        .store_en   (store_en),
        .hlt        (hlt)
    );

    tinker_alu u_alu (
        .instr      (instr),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_result (alu_result),
        .alu_writes (alu_writes)
    );

    tinker_branch_unit u_branch_unit (
        .instr     (instr),
        .pc        (pc),
        .op_a      (op_a),
        .op_b      (op_b),
        .branch_pc (branch_pc),
        .mem_addr  (mem_addr)
    );

    tinker_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rf_addr_a (rf_addr_a),
        .rf_addr_b (rf_addr_b),
        .rf_waddr  (rf_waddr),
        .dbg_addr  (dbg_addr),
        .rf_we     (rf_we),
        .rf_wdata  (rf_wdata),
        .op_a      (op_a),
        .op_b      (op_b),
        .dbg_data  (dbg_data)
    );

    tinker_memory #(
        .MEM_BYTES (MEM_BYTES)
    ) u_memory (
        .clk        (clk),
        .pc         (pc),
        .fetch_word (fetch_word),
        .mem_addr   (mem_addr),
        .load_data  (load_data),
        .store_en   (store_en),
        .store_data (op_b),         // Store value comes from rs on port B
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

endmodule

// File: control/tinker_sequencer.sv
// Tinker control FSM; holds PC and instruction, picks register ports and commits write-back
`timescale 1ns/1ps

module tinker_sequencer #(
    parameter tinker_core_pkg::addr_t RESET_PC = 32'h0000_2000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  tinker_isa_pkg::instr_t    fetch_word,
    input  tinker_core_pkg::word_t    op_a,
    input  tinker_core_pkg::word_t    alu_result,
    input  logic                      alu_writes,
    input  tinker_core_pkg::addr_t    branch_pc,
    input  tinker_core_pkg::word_t    load_data,
    output tinker_isa_pkg::instr_t    instr,
    output tinker_core_pkg::addr_t    pc,
    output tinker_isa_pkg::reg_idx_t  rf_addr_a,
    output tinker_isa_pkg::reg_idx_t  rf_addr_b,
    output tinker_isa_pkg::reg_idx_t  rf_waddr,
    output logic                      rf_we,
    output tinker_core_pkg::word_t    rf_wdata,
    output logic                      store_en,
    output logic                      hlt
);

    tinker_core_pkg::state_t state;
    tinker_core_pkg::state_t state_next;
    logic                    is_load;
    logic                    is_store;
    logic                    in_writeback;

    always_comb begin
        case (state)
            tinker_core_pkg::FETCH:     state_next = tinker_core_pkg::DECODE;
            tinker_core_pkg::DECODE: begin
                if (instr.opcode == tinker_isa_pkg::OP_HALT)
                    state_next = tinker_core_pkg::HALTED;   // Park until reset
                else
                    state_next = tinker_core_pkg::EXECUTE;
            end
            tinker_core_pkg::EXECUTE:   state_next = tinker_core_pkg::MEMORY;
            tinker_core_pkg::MEMORY:    state_next = tinker_core_pkg::WRITEBACK;
            tinker_core_pkg::WRITEBACK: state_next = tinker_core_pkg::FETCH;
            tinker_core_pkg::HALTED:    state_next = tinker_core_pkg::HALTED;
            default:                    state_next = tinker_core_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= tinker_core_pkg::FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (in_writeback)
                pc <= branch_pc;    // Every instruction commits its next PC here
        end
    end

    // Instruction register, captured at the end of FETCH
    always_ff @(posedge clk) begin
        if (state == tinker_core_pkg::FETCH)
            instr <= fetch_word;
    end

    // Read port selection; immediates, branches and store read rd
    always_comb begin
        rf_addr_a = instr.rs;
        rf_addr_b = instr.rt;
        case (instr.opcode)
            tinker_isa_pkg::OP_ADDI,
            tinker_isa_pkg::OP_SUBI,
            tinker_isa_pkg::OP_SHFTRI,
            tinker_isa_pkg::OP_SHFTLI,
            tinker_isa_pkg::OP_MOV_L,
            tinker_isa_pkg::OP_BR,
            tinker_isa_pkg::OP_BRR_RD: begin
                rf_addr_a = instr.rd;
            end
            tinker_isa_pkg::OP_BRNZ: begin
                rf_addr_b = instr.rd;           // Target on B, condition rs on A
            end
            tinker_isa_pkg::OP_STORE: begin
                rf_addr_a = instr.rd;           // Base address
                rf_addr_b = instr.rs;           // Value to store
            end
            default: begin
                rf_addr_a = instr.rs;
            end
        endcase
    end

    assign is_load      = (instr.opcode == tinker_isa_pkg::OP_LOAD);
    assign is_store     = (instr.opcode == tinker_isa_pkg::OP_STORE);
    assign in_writeback = (state == tinker_core_pkg::WRITEBACK);

    assign rf_waddr = instr.rd;
    assign rf_wdata = is_load ? load_data : alu_result;
    assign rf_we    = in_writeback && (alu_writes || is_load);
    assign store_en = in_writeback && is_store;
    assign hlt      = (state == tinker_core_pkg::HALTED);

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {tinker_core_pkg::FETCH, tinker_core_pkg::DECODE,
                      tinker_core_pkg::EXECUTE, tinker_core_pkg::MEMORY,
                      tinker_core_pkg::WRITEBACK, tinker_core_pkg::HALTED});

    a_write_xor_store: assert property (@(posedge clk) disable iff (reset)
        !(rf_we && store_en));

    // Register jump lands on the address read from rd
    a_br_target: assert property (@(posedge clk) disable iff (reset)
        (in_writeback && instr.opcode == tinker_isa_pkg::OP_BR) |=> (pc == $past(op_a[31:0])));

endmodule

// File: execute/tinker_branch_unit.sv
// Tinker branch and address unit; combinational next PC and load/store address
`timescale 1ns/1ps

module tinker_branch_unit (
    input  tinker_isa_pkg::instr_t  instr,
    input  tinker_core_pkg::addr_t  pc,
    input  tinker_core_pkg::word_t  op_a,
    input  tinker_core_pkg::word_t  op_b,
    output tinker_core_pkg::addr_t  branch_pc,
    output tinker_core_pkg::addr_t  mem_addr
);

    localparam int PAD = tinker_core_pkg::ADDR_WIDTH - tinker_isa_pkg::LITERAL_WIDTH;

    tinker_core_pkg::addr_t pc_seq;
    tinker_core_pkg::addr_t lit_sext;
    tinker_core_pkg::addr_t lit_zext;

    assign pc_seq   = pc + tinker_core_pkg::addr_t'(tinker_isa_pkg::INSTR_BYTES);
    assign lit_sext = {{PAD{instr.l[tinker_isa_pkg::LITERAL_WIDTH-1]}}, instr.l};
    assign lit_zext = {{PAD{1'b0}}, instr.l};

    always_comb begin
        case (instr.opcode)
            tinker_isa_pkg::OP_BR:     branch_pc = op_a[31:0];
            tinker_isa_pkg::OP_BRR_RD: branch_pc = pc + op_a[31:0];
            tinker_isa_pkg::OP_BRR_L:  branch_pc = pc + lit_sext;
            tinker_isa_pkg::OP_BRNZ: begin
                if (op_a != '0)
                    branch_pc = op_b[31:0];     // rd holds the target
                else
                    branch_pc = pc_seq;
            end
            default:                   branch_pc = pc_seq;
        endcase
    end

    // Base is rs for load and rd for store, both arrive on port A
    assign mem_addr = op_a[31:0] + lit_zext;

endmodule

// File: execute/tinker_alu.sv
// Tinker integer ALU; combinational arithmetic, logic, shift and move results for write-back
`timescale 1ns/1ps

module tinker_alu (
    input  tinker_isa_pkg::instr_t  instr,
    input  tinker_core_pkg::word_t  op_a,
    input  tinker_core_pkg::word_t  op_b,
    output tinker_core_pkg::word_t  alu_result,
    output logic                    alu_writes
);

    tinker_core_pkg::word_t lit_zext;
    logic [5:0]             shamt;

    assign lit_zext = {{(tinker_core_pkg::XLEN - tinker_isa_pkg::LITERAL_WIDTH){1'b0}}, instr.l};
    assign shamt    = op_b[5:0];   // Register shifts use the low 6 bits only

    always_comb begin
        alu_writes = 1'b1;
        case (instr.opcode)
            tinker_isa_pkg::OP_ADD:    alu_result = op_a + op_b;
            tinker_isa_pkg::OP_ADDI:   alu_result = op_a + lit_zext;
            tinker_isa_pkg::OP_SUB:    alu_result = op_a - op_b;
            tinker_isa_pkg::OP_SUBI:   alu_result = op_a - lit_zext;
            tinker_isa_pkg::OP_MUL:    alu_result = op_a * op_b;      // Low 64 bits
            tinker_isa_pkg::OP_AND:    alu_result = op_a & op_b;
            tinker_isa_pkg::OP_OR:     alu_result = op_a | op_b;
            tinker_isa_pkg::OP_XOR:    alu_result = op_a ^ op_b;
            tinker_isa_pkg::OP_NOT:    alu_result = ~op_a;
            tinker_isa_pkg::OP_SHFTR:  alu_result = op_a >> shamt;
            tinker_isa_pkg::OP_SHFTRI: alu_result = op_a >> instr.l;
            tinker_isa_pkg::OP_SHFTL:  alu_result = op_a << shamt;
            tinker_isa_pkg::OP_SHFTLI: alu_result = op_a << instr.l;
            tinker_isa_pkg::OP_MOV:    alu_result = op_a;
            tinker_isa_pkg::OP_MOV_L: begin
                // Upper bits of rd survive
                alu_result = {op_a[tinker_core_pkg::XLEN-1:tinker_isa_pkg::LITERAL_WIDTH],
                              instr.l};
            end
            default: begin
                alu_result = '0;
                alu_writes = 1'b0;     // Branches, memory ops, halt, unknown
            end
        endcase
    end

endmodule

// File: hdl/tinker_memory.sv
// Tinker unified memory; byte array with little-endian fetch, load, store and program write
`timescale 1ns/1ps

module tinker_memory #(
    parameter int MEM_BYTES = 16384
) (
    input  logic                    clk,
    input  tinker_core_pkg::addr_t  pc,
    output tinker_isa_pkg::instr_t  fetch_word,
    input  tinker_core_pkg::addr_t  mem_addr,
    output tinker_core_pkg::word_t  load_data,
    input  logic                    store_en,
    input  tinker_core_pkg::word_t  store_data,
    input  logic                    prog_we,
    input  tinker_core_pkg::addr_t  prog_addr,
    input  tinker_isa_pkg::instr_t  prog_data
);

    localparam int WORD_BYTES  = tinker_core_pkg::XLEN / 8;
    localparam int INSTR_BYTES = tinker_isa_pkg::INSTR_BYTES;

    logic [7:0]                          mem [MEM_BYTES];
    logic [tinker_isa_pkg::INSTR_WIDTH-1:0] fetch_bits;

    // Lowest address holds the least significant byte
    always_comb begin
        for (int i = 0; i < INSTR_BYTES; i++) begin
            fetch_bits[8*i +: 8] = mem[pc + tinker_core_pkg::addr_t'(i)];
        end
    end

    assign fetch_word = tinker_isa_pkg::instr_t'(fetch_bits);

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            load_data[8*i +: 8] = mem[mem_addr + tinker_core_pkg::addr_t'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[mem_addr + tinker_core_pkg::addr_t'(i)] <= store_data[8*i +: 8];
            end
        end
        if (prog_we) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                mem[prog_addr + tinker_core_pkg::addr_t'(i)] <= prog_data[8*i +: 8];
            end
        end
    end

    // Store address comes from the register file through the branch unit
    a_store_in_range: assert property (@(posedge clk)
        store_en |-> (longint'(mem_addr) + WORD_BYTES <= longint'(MEM_BYTES)));

    a_prog_in_range: assert property (@(posedge clk)
        prog_we |-> (longint'(prog_addr) + INSTR_BYTES <= longint'(MEM_BYTES)));

endmodule

// File: hdl/tinker_regfile.sv
// Tinker register file; 32 x 64-bit with two operand reads, a debug read and one write
`timescale 1ns/1ps

module tinker_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  tinker_isa_pkg::reg_idx_t  rf_addr_a,
    input  tinker_isa_pkg::reg_idx_t  rf_addr_b,
    input  tinker_isa_pkg::reg_idx_t  rf_waddr,
    input  tinker_isa_pkg::reg_idx_t  dbg_addr,
    input  logic                      rf_we,
    input  tinker_core_pkg::word_t    rf_wdata,
    output tinker_core_pkg::word_t    op_a,
    output tinker_core_pkg::word_t    op_b,
    output tinker_core_pkg::word_t    dbg_data
);

    tinker_core_pkg::word_t regs [tinker_core_pkg::NUM_REGS];

    // r0 is writable like any other register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < tinker_core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign op_a     = regs[rf_addr_a];
    assign op_b     = regs[rf_addr_b];
    assign dbg_data = regs[dbg_addr];     // Testbench observation

endmodule

// File: common/tinker_core_pkg.sv
// Tinker microarchitecture definitions shared by the core, register file and memory
package tinker_core_pkg;

    localparam int XLEN       = 64;
    localparam int ADDR_WIDTH = 32;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One instruction in flight, walked through these states in order
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } state_t;

endpackage

// File: common/tinker_isa_pkg.sv
// Tinker instruction-set definitions (opcodes and instruction fields) used by decode and execute
package tinker_isa_pkg;

    localparam int OPCODE_WIDTH  = 5;
    localparam int REG_IDX_WIDTH = 5;
    localparam int LITERAL_WIDTH = 12;
    localparam int INSTR_WIDTH   = 32;
    localparam int INSTR_BYTES   = 4;   // PC step per instruction

    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [LITERAL_WIDTH-1:0] literal_t;

    // Integer subset of the opcode map
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR_RD = 5'h09,
        OP_BRR_L  = 5'h0a,
        OP_BRNZ   = 5'h0b,
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,
        OP_MOV    = 5'h11,
        OP_MOV_L  = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    // opcode [31:27], rd [26:22], rs [21:17], rt [16:12], L [11:0]
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        literal_t l;
    } instr_t;

endpackage
